/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_iq_demod
FLIST     = flist.f

BIN = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

/* flist.f */
rtl/demod_pkg.sv
rtl/config_regs.sv
rtl/trigger_delay.sv
rtl/phase_sequencer.sv
rtl/iq_rotator.sv
rtl/iq_integrator.sv
rtl/iq_demod_top.sv
tb/tb_iq_demod.sv

/* rtl/config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module config_regs import demod_pkg::*; (
    input  wire logic               clk100,
    input  wire logic               reset,
    input  wire logic               i_cfg_wr,
    input  wire logic [ADDR_W-1:0]  i_cfg_addr,
    input  wire logic [DATA_W-1:0]  i_cfg_data,
    output logic      [FREQ_W-1:0]  o_demod_freq,     // in 10 MHz steps
    output logic      [LEN_W-1:0]   o_sample_len,     // clocks per window
    output logic      [DELAY_W-1:0] o_delay_cycles    // clocks after trigger
);

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_demod_freq   <= DEF_FREQ;
            o_sample_len   <= DEF_LEN;
            o_delay_cycles <= DEF_DELAY;
        end else if (i_cfg_wr) begin
            // only the low bits of the data word are kept
            case (i_cfg_addr)
                ADDR_FREQ:  o_demod_freq   <= i_cfg_data[FREQ_W-1:0];
                ADDR_LEN:   o_sample_len   <= i_cfg_data[LEN_W-1:0];
                ADDR_DELAY: o_delay_cycles <= i_cfg_data[DELAY_W-1:0];
                default: ;                  // unmapped, dropped
            endcase
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // checks
    ///////////////////////////////////////////////////////////////////////

    // phase steps wrap at the modulus, a larger frequency aliases
    a_freq_range: assert property (
        @(posedge clk100) disable iff (reset)
        (i_cfg_wr && i_cfg_addr == ADDR_FREQ) |-> (i_cfg_data < DATA_W'(PHASE_MOD))
    ) else $error("demodulation frequency write out of range");

endmodule

`default_nettype wire

/* rtl/demod_pkg.sv */
`default_nettype none

package demod_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int PHASE_MOD = 50;      // one phase step per 10 MHz
    localparam int PHASE_W   = 6;
    localparam int FREQ_W    = 5;
    localparam int LEN_W     = 11;
    localparam int DELAY_W   = 14;
    localparam int ADDR_W    = 14;
    localparam int DATA_W    = 32;
    localparam int TRIG_W    = 16;      // q1.15
    localparam int ROT_W     = 33;
    localparam int ACC_W     = 48;
    localparam int TOT_W     = 32;

    // register map
    localparam logic [ADDR_W-1:0] ADDR_FREQ  = ADDR_W'(0);
    localparam logic [ADDR_W-1:0] ADDR_LEN   = ADDR_W'(20);
    localparam logic [ADDR_W-1:0] ADDR_DELAY = ADDR_W'(22);

    localparam logic [FREQ_W-1:0]  DEF_FREQ  = FREQ_W'(5);     // 50 MHz
    localparam logic [LEN_W-1:0]   DEF_LEN   = LEN_W'(20);
    localparam logic [DELAY_W-1:0] DEF_DELAY = DELAY_W'(5);

    ///////////////////////////////////////////////////////////////////////
    // sine rom source
    ///////////////////////////////////////////////////////////////////////

    // table resolution is half a phase step, so cosine lands on a whole entry
    localparam int HALF_STEPS = 2 * PHASE_MOD;
    localparam int QUARTER    = HALF_STEPS / 4;

    // round(32767 * sin(2*pi*h/100)) for the first quarter period
    localparam int QUARTER_SINE [0:25] = '{
            0,  2057,  4107,  6140,  8149, 10126, 12062, 13952, 15786,
        17557, 19260, 20886, 22431, 23886, 25247, 26509, 27666, 28714,
        29648, 30466, 31163, 31738, 32187, 32509, 32702, 32767
    };

    // argument counts half phase steps: sine of step k is 2k, cosine is 2k + 25
    function automatic int trig_value(input int half_step);
        int h;
        h = half_step % HALF_STEPS;
        if (h <= QUARTER)
            return QUARTER_SINE[h];
        else if (h <= 2 * QUARTER)
            return QUARTER_SINE[2 * QUARTER - h];   // mirrored rise
        else if (h <= 3 * QUARTER)
            return -QUARTER_SINE[h - 2 * QUARTER];
        else
            return -QUARTER_SINE[HALF_STEPS - h];
    endfunction

endpackage

`default_nettype wire

/* rtl/iq_demod_top.sv */
`timescale 1ns/100ps
`default_nettype none

module iq_demod_top import demod_pkg::*; #(
    parameter int LANES = 5                 // samples per clock, 500 MS/s
) (
    input  wire logic                                  clk100,
    input  wire logic                                  reset,
    input  wire logic                                  i_cfg_wr,
    input  wire logic        [ADDR_W-1:0]              i_cfg_addr,
    input  wire logic        [DATA_W-1:0]              i_cfg_data,
    input  wire logic                                  i_trigger,
    input  wire logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_i,
    input  wire logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_q,
    output logic                                       o_iq_valid,
    output logic signed      [TOT_W-1:0]               o_i_total,
    output logic signed      [TOT_W-1:0]               o_q_total
);

    logic        [FREQ_W-1:0]              demod_freq;
    logic        [LEN_W-1:0]               sample_len;
    logic        [DELAY_W-1:0]             delay_cycles;
    logic                                  start;
    logic                                  busy;
    logic                                  seq_valid;
    logic        [LANES-1:0][PHASE_W-1:0]  seq_phase;
    logic signed [LANES-1:0][SAMPLE_W-1:0] seq_data_i;
    logic signed [LANES-1:0][SAMPLE_W-1:0] seq_data_q;
    logic                                  rot_valid;
    logic signed [LANES-1:0][ROT_W-1:0]    rot_i;
    logic signed [LANES-1:0][ROT_W-1:0]    rot_q;

    ///////////////////////////////////////////////////////////////////////
    // control
    ///////////////////////////////////////////////////////////////////////

    config_regs u_config_regs (
        .clk100         (clk100),
        .reset          (reset),
        .i_cfg_wr       (i_cfg_wr),
        .i_cfg_addr     (i_cfg_addr),
        .i_cfg_data     (i_cfg_data),
        .o_demod_freq   (demod_freq),
        .o_sample_len   (sample_len),
        .o_delay_cycles (delay_cycles)
    );

    trigger_delay u_trigger_delay (
        .clk100         (clk100),
        .reset          (reset),
        .i_trigger      (i_trigger),
        .i_busy         (busy),             // blocks retrigger during a window
        .i_delay_cycles (delay_cycles),
        .o_start        (start)
    );

    ///////////////////////////////////////////////////////////////////////
    // datapath
    ///////////////////////////////////////////////////////////////////////

    phase_sequencer #(.LANES(LANES)) u_phase_sequencer (
        .clk100       (clk100),
        .reset        (reset),
        .i_start      (start),
        .i_demod_freq (demod_freq),
        .i_sample_len (sample_len),
        .i_data_i     (i_data_i),
        .i_data_q     (i_data_q),
        .o_busy       (busy),
        .o_valid      (seq_valid),
        .o_phase      (seq_phase),
        .o_data_i     (seq_data_i),
        .o_data_q     (seq_data_q)
    );

    iq_rotator #(.LANES(LANES)) u_iq_rotator (
        .clk100   (clk100),
        .reset    (reset),
        .i_valid  (seq_valid),
        .i_phase  (seq_phase),
        .i_data_i (seq_data_i),
        .i_data_q (seq_data_q),
        .o_valid  (rot_valid),
        .o_rot_i  (rot_i),
        .o_rot_q  (rot_q)
    );

    iq_integrator #(.LANES(LANES)) u_iq_integrator (
        .clk100     (clk100),
        .reset      (reset),
        .i_valid    (rot_valid),
        .i_rot_i    (rot_i),
        .i_rot_q    (rot_q),
        .o_iq_valid (o_iq_valid),
        .o_i_total  (o_i_total),
        .o_q_total  (o_q_total)
    );

endmodule

`default_nettype wire

/* rtl/iq_integrator.sv */
`timescale 1ns/100ps
`default_nettype none

module iq_integrator import demod_pkg::*; #(
    parameter int LANES = 5
) (
    input  wire logic                               clk100,
    input  wire logic                               reset,
    input  wire logic                               i_valid,
    input  wire logic signed [LANES-1:0][ROT_W-1:0] i_rot_i,
    input  wire logic signed [LANES-1:0][ROT_W-1:0] i_rot_q,
    output logic                                    o_iq_valid,
    output logic signed      [TOT_W-1:0]            o_i_total,
    output logic signed      [TOT_W-1:0]            o_q_total
);

    localparam int FRAC = TRIG_W - 1;      // rom fraction bits

    logic signed [ACC_W-1:0] sum_i;        // all lanes of one clock
    logic signed [ACC_W-1:0] sum_q;
    logic signed [ACC_W-1:0] acc_i;
    logic signed [ACC_W-1:0] acc_q;
    logic signed [TOT_W-1:0] hold_i;
    logic signed [TOT_W-1:0] hold_q;
    logic                    valid_d;
    logic                    done;

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int l = 0; l < LANES; l++) begin
            sum_i = sum_i + ACC_W'($signed(i_rot_i[l]));
            sum_q = sum_q + ACC_W'($signed(i_rot_q[l]));
        end
    end

    always_ff @(posedge clk100) begin
        if (reset)
            valid_d <= 1'b0;
        else
            valid_d <= i_valid;
    end

    // first valid clock of a window restarts the sum
    always_ff @(posedge clk100) begin
        if (i_valid) begin
            acc_i <= valid_d ? acc_i + sum_i : sum_i;
            acc_q <= valid_d ? acc_q + sum_q : sum_q;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // result
    ///////////////////////////////////////////////////////////////////////

    // acc is complete on the falling edge of valid
    assign done = valid_d && !i_valid;

    always_ff @(posedge clk100) begin
        if (reset) begin
            hold_i <= '0;
            hold_q <= '0;
        end else if (done) begin
            hold_i <= acc_i[FRAC +: TOT_W];     // >>> 15 and truncated
            hold_q <= acc_q[FRAC +: TOT_W];
        end
    end

    // pulse cycle reads the accumulator directly and later cycles the held copy
    assign o_iq_valid = done;
    assign o_i_total  = done ? acc_i[FRAC +: TOT_W] : hold_i;
    assign o_q_total  = done ? acc_q[FRAC +: TOT_W] : hold_q;

endmodule

`default_nettype wire

/* rtl/iq_rotator.sv */
`timescale 1ns/100ps
`default_nettype none

module iq_rotator import demod_pkg::*; #(
    parameter int LANES = 5
) (
    input  wire logic                                  clk100,
    input  wire logic                                  reset,
    input  wire logic                                  i_valid,
    input  wire logic        [LANES-1:0][PHASE_W-1:0]  i_phase,
    input  wire logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_i,
    input  wire logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_q,
    output logic                                       o_valid,
    output logic signed      [LANES-1:0][ROT_W-1:0]    o_rot_i,
    output logic signed      [LANES-1:0][ROT_W-1:0]    o_rot_q
);

    function automatic logic [PHASE_MOD-1:0][TRIG_W-1:0] build_table(input int offset);
        logic [PHASE_MOD-1:0][TRIG_W-1:0] tab;
        for (int k = 0; k < PHASE_MOD; k++) begin
            tab[k] = TRIG_W'(trig_value(2 * k + offset));
        end
        return tab;
    endfunction

    // cosine is sine a quarter period on
    localparam logic [PHASE_MOD-1:0][TRIG_W-1:0] SIN_TAB = build_table(0);
    localparam logic [PHASE_MOD-1:0][TRIG_W-1:0] COS_TAB = build_table(QUARTER);

    logic signed [TRIG_W-1:0]   sin_s1 [LANES];
    logic signed [TRIG_W-1:0]   cos_s1 [LANES];
    logic signed [SAMPLE_W-1:0] di_s1  [LANES];
    logic signed [SAMPLE_W-1:0] dq_s1  [LANES];
    logic                       valid_s1;

    ///////////////////////////////////////////////////////////////////////
    // stage 1: rom lookup
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100) begin
        for (int l = 0; l < LANES; l++) begin
            sin_s1[l] <= SIN_TAB[i_phase[l]];
            cos_s1[l] <= COS_TAB[i_phase[l]];
            di_s1[l]  <= i_data_i[l];           // align with rom output
            dq_s1[l]  <= i_data_q[l];
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // stage 2: complex rotation
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100) begin
        for (int l = 0; l < LANES; l++) begin
            o_rot_i[l] <= ROT_W'(di_s1[l]) * ROT_W'(cos_s1[l])
                        + ROT_W'(dq_s1[l]) * ROT_W'(sin_s1[l]);
            o_rot_q[l] <= ROT_W'(dq_s1[l]) * ROT_W'(cos_s1[l])
                        - ROT_W'(di_s1[l]) * ROT_W'(sin_s1[l]);
        end
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            valid_s1 <= i_valid;
            o_valid  <= valid_s1;
        end
    end

endmodule

`default_nettype wire

/* rtl/phase_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module phase_sequencer import demod_pkg::*; #(
    parameter int LANES = 5
) (
    input  wire logic                                clk100,
    input  wire logic                                reset,
    input  wire logic                                i_start,
    input  wire logic        [FREQ_W-1:0]            i_demod_freq,
    input  wire logic        [LEN_W-1:0]             i_sample_len,
    input  wire logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_i,
    input  wire logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_q,
    output logic                                     o_busy,
    output logic                                     o_valid,
    output logic             [LANES-1:0][PHASE_W-1:0]  o_phase,
    output logic signed      [LANES-1:0][SAMPLE_W-1:0] o_data_i,
    output logic signed      [LANES-1:0][SAMPLE_W-1:0] o_data_q
);

    logic [LEN_W-1:0]              cnt;         // index of the output cycle
    logic [LEN_W-1:0]              len_q;
    logic [FREQ_W-1:0]             freq_q;
    logic [PHASE_W-1:0]            base;        // lane 0 phase of the samples at the input
    logic                          launch;
    logic [FREQ_W-1:0]             freq;
    logic [PHASE_W-1:0]            base_now;
    logic [PHASE_W-1:0]            step;
    logic [LANES-1:0][PHASE_W-1:0] lane_phase;

    function automatic logic [PHASE_W-1:0] wrap_add(input logic [PHASE_W-1:0] a,
                                                    input logic [PHASE_W-1:0] b);
        logic [PHASE_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= (PHASE_W+1)'(PHASE_MOD))
            s = s - (PHASE_W+1)'(PHASE_MOD);
        return s[PHASE_W-1:0];
    endfunction

    assign launch   = i_start && !o_valid && (i_sample_len != '0);
    assign freq     = launch ? i_demod_freq : freq_q;   // first cycle sees the live value
    assign base_now = launch ? '0 : base;
    assign step     = PHASE_W'((LANES * int'(freq)) % PHASE_MOD);
    assign o_busy   = i_start || o_valid;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_phase[l] = wrap_add(base_now, PHASE_W'((l * int'(freq)) % PHASE_MOD));
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // window control
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_valid <= 1'b0;
            cnt     <= '0;
        end else if (launch) begin
            o_valid <= 1'b1;
            cnt     <= LEN_W'(1);
        end else if (o_valid) begin
            if (cnt >= len_q)
                o_valid <= 1'b0;        // last output cycle
            else
                cnt <= cnt + LEN_W'(1);
        end
    end

    always_ff @(posedge clk100) begin
        if (launch) begin
            freq_q <= i_demod_freq;
            len_q  <= i_sample_len;
        end
        if (launch || o_valid)
            base <= wrap_add(base_now, step);
        o_phase  <= lane_phase;
        o_data_i <= i_data_i;
        o_data_q <= i_data_q;
    end

endmodule

`default_nettype wire

/* rtl/trigger_delay.sv */
`timescale 1ns/100ps
`default_nettype none

module trigger_delay import demod_pkg::*; (
    input  wire logic               clk100,
    input  wire logic               reset,
    input  wire logic               i_trigger,
    input  wire logic               i_busy,          // window already running
    input  wire logic [DELAY_W-1:0] i_delay_cycles,
    output logic                    o_start
);

    localparam logic IDLE  = 1'b0;
    localparam logic COUNT = 1'b1;

    logic               state;
    logic [DELAY_W-1:0] cnt;

    always_ff @(posedge clk100) begin
        if (reset) begin
            state   <= IDLE;
            cnt     <= '0;
            o_start <= 1'b0;
        end else begin
            o_start <= 1'b0;                // strobe
            case (state)
                IDLE: begin
                    if (i_trigger && !i_busy) begin
                        if (i_delay_cycles == '0) begin
                            o_start <= 1'b1;    // no wait, start on the next clock
                        end else begin
                            state <= COUNT;
                            cnt   <= DELAY_W'(1);
                        end
                    end
                end
                COUNT: begin
                    // >= covers a delay lowered while counting
                    if (cnt >= i_delay_cycles) begin
                        o_start <= 1'b1;
                        state   <= IDLE;
                    end else begin
                        cnt <= cnt + DELAY_W'(1);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // relies on busy from the sequencer covering the start cycle
    a_start_single: assert property (
        @(posedge clk100) disable iff (reset)
        o_start |=> !o_start
    ) else $error("start pulse longer than one cycle");

endmodule

`default_nettype wire

/* tb/iq_stimulus.txt */
# columns: test freq len delay mode i q exp_i_total exp_q_total
# -1 keeps the register, mode 1 adds a write to address 30, mode 2 retriggers inside the window
1  -1 -1 -1  0   1234  -567      0      0
2   1  2  3  0     64    32    666    -69
3   7  2  1  0   -512   256   -367   1225
4  25  3  7  0   1000 -2000    999  -2000
5   5  1  0  0   4096  4096  16701  -8510
6  -1 -1 -1  1   4096  4096  16701  -8510
7   1  2  2  2   -100     0   -791    501
8   7  1  4  0  -2048 -1024  -1182   4186
9  25  4  2  0   3000 -3000      0      0

/* tb/tb_iq_demod.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_iq_demod import demod_pkg::*; ();

    localparam int    LANES          = 5;
    localparam int    WAIT_SLACK     = 40;      // cycles past the expected pulse
    localparam int    MAX_LINES      = 200;
    localparam int    MODE_UNMAPPED  = 1;
    localparam int    MODE_RETRIGGER = 2;
    localparam int    UNMAPPED_ADDR  = 30;
    localparam string STIM_FILE      = "tb/iq_stimulus.txt";

    logic                                  clk100 = 1'b0;
    logic                                  reset;
    logic                                  i_cfg_wr;
    logic        [ADDR_W-1:0]              i_cfg_addr;
    logic        [DATA_W-1:0]              i_cfg_data;
    logic                                  i_trigger;
    logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_i;
    logic signed [LANES-1:0][SAMPLE_W-1:0] i_data_q;
    logic                                  o_iq_valid;
    logic signed [TOT_W-1:0]               o_i_total;
    logic signed [TOT_W-1:0]               o_q_total;

    int cur_freq;       // register contents as the DUT should hold them
    int cur_len;
    int cur_delay;
    int prev_i;         // totals of the last pulse
    int prev_q;
    int err_count;
    int tests_run;
    int tests_passed;

    always #5 clk100 = ~clk100;

    iq_demod_top #(.LANES(LANES)) i_dut (
        .clk100     (clk100),
        .reset      (reset),
        .i_cfg_wr   (i_cfg_wr),
        .i_cfg_addr (i_cfg_addr),
        .i_cfg_data (i_cfg_data),
        .i_trigger  (i_trigger),
        .i_data_i   (i_data_i),
        .i_data_q   (i_data_q),
        .o_iq_valid (o_iq_valid),
        .o_i_total  (o_i_total),
        .o_q_total  (o_q_total)
    );

    //////////////////////////////////////////////////////////////////////
    // bus and window tasks
    //////////////////////////////////////////////////////////////////////

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk100);
        i_cfg_wr   <= 1'b1;
        i_cfg_addr <= addr;
        i_cfg_data <= data;
    endtask

    task automatic apply_config(input int freq, input int len, input int delay, input int mode);
        bit wrote;
        wrote = 1'b0;
        if (mode == MODE_UNMAPPED) begin
            write_reg(ADDR_W'(UNMAPPED_ADDR), DATA_W'(3));     // must be dropped
            wrote = 1'b1;
        end
        if (freq >= 0) begin
            write_reg(ADDR_FREQ, DATA_W'(freq));
            cur_freq = freq;
            wrote    = 1'b1;
        end
        if (len >= 0) begin
            write_reg(ADDR_LEN, DATA_W'(len));
            cur_len = len;
            wrote   = 1'b1;
        end
        if (delay >= 0) begin
            write_reg(ADDR_DELAY, DATA_W'(delay));
            cur_delay = delay;
            wrote     = 1'b1;
        end
        if (wrote) begin
            @(posedge clk100);
            i_cfg_wr <= 1'b0;
        end
    endtask

    task automatic run_window(input string name, input int ival, input int qval,
                              input int exp_i, input int exp_q, input bit retrigger);
        int lat_exp;
        int cycles;
        int gap;
        int errs_at_start;
        int got_i;
        int got_q;
        bit seen;
        bit held_bad;
        lat_exp       = cur_delay + cur_len + 4;
        errs_at_start = err_count;
        cycles        = 0;
        seen          = 1'b0;
        held_bad      = 1'b0;
        @(posedge clk100);
        for (int l = 0; l < LANES; l++) begin
            i_data_i[l] <= SAMPLE_W'(ival);
            i_data_q[l] <= SAMPLE_W'(qval);
        end
        i_trigger <= 1'b1;
        @(negedge clk100);                      // cycle 0, trigger high
        while (!seen && cycles < lat_exp + WAIT_SLACK) begin
            @(posedge clk100);
            cycles++;
            i_trigger <= retrigger && (cycles == cur_delay + 2);   // inside the window
            @(negedge clk100);
            if (o_iq_valid) begin
                seen = 1'b1;
            end else if (!held_bad && (o_i_total !== prev_i || o_q_total !== prev_q)) begin
                $display("Mismatch %s held totals: expected %0d/%0d, actual %0d/%0d",
                         name, prev_i, prev_q, o_i_total, o_q_total);
                held_bad = 1'b1;
                err_count++;
            end
        end
        if (!seen) begin
            $display("%s: no result pulse within %0d cycles of the trigger", name, cycles);
            err_count++;
        end else begin
            got_i = o_i_total;
            got_q = o_q_total;
            if (cycles != lat_exp) begin
                $display("Mismatch %s latency: expected %0d, actual %0d", name, lat_exp, cycles);
                err_count++;
            end
            if (got_i != exp_i) begin
                $display("Mismatch %s i_total: expected %0d, actual %0d", name, exp_i, got_i);
                err_count++;
            end
            if (got_q != exp_q) begin
                $display("Mismatch %s q_total: expected %0d, actual %0d", name, exp_q, got_q);
                err_count++;
            end
            prev_i = got_i;
            prev_q = got_q;
            // quiet stretch after the pulse, longer when a retrigger was sent
            gap = retrigger ? cur_len + 10 : 2 + int'($urandom % 7);
            for (int c = 1; c <= gap; c++) begin
                @(negedge clk100);
                if (o_iq_valid) begin
                    $display("%s: extra result pulse %0d cycles after the first", name, c);
                    err_count++;
                end
                if (o_i_total !== prev_i || o_q_total !== prev_q) begin
                    $display("Mismatch %s held totals: expected %0d/%0d, actual %0d/%0d",
                             name, prev_i, prev_q, o_i_total, o_q_total);
                    err_count++;
                end
            end
        end
        tests_run++;
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            $display("%s: failed", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int     fd;
        int     code;
        int     n_lines;
        int     n_file_tests;
        int     num;
        int     freq;
        int     len;
        int     delay;
        int     mode;
        int     ival;
        int     qval;
        int     exp_i;
        int     exp_q;
        longint prod;
        string  line;
        reset        = 1'b1;
        i_cfg_wr     = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_data   = '0;
        i_trigger    = 1'b0;
        i_data_i     = '0;
        i_data_q     = '0;
        cur_freq     = 5;       // register defaults after reset
        cur_len      = 20;
        cur_delay    = 5;
        prev_i       = 0;
        prev_q       = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_passed = 0;
        n_lines      = 0;
        n_file_tests = 0;
        void'($urandom(6));
        repeat (10) @(posedge clk100);
        reset <= 1'b0;
        @(negedge clk100);

        tests_run++;
        if (o_iq_valid !== 1'b0 || o_i_total !== '0 || o_q_total !== '0) begin
            $display("reset_state: outputs not idle after reset");
            err_count++;
            $display("reset_state: failed");
        end else begin
            tests_passed++;
            $display("reset_state: ok");
        end

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            err_count++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                n_lines++;
                code = $fgets(line, fd);
                if (code > 0 && $sscanf(line, "%d %d %d %d %d %d %d %d %d", num, freq, len,
                                        delay, mode, ival, qval, exp_i, exp_q) == 9) begin
                    n_file_tests++;
                    apply_config(freq, len, delay, mode);
                    run_window($sformatf("test%0d_f%0d_len%0d", num, cur_freq, cur_len),
                               ival, qval, exp_i, exp_q, mode == MODE_RETRIGGER);
                end
            end
            $fclose(fd);
            if (n_file_tests == 0) begin
                $display("no test lines found in stimulus file %s", STIM_FILE);
                err_count++;
            end
        end

        // phase stays 0, so every lane sees cosine at full scale and sine at 0
        apply_config(0, 6, 4, 0);
        prod  = longint'(-3000) * 32767 * LANES * cur_len;
        exp_i = int'(prod >>> 15);
        prod  = longint'(1500) * 32767 * LANES * cur_len;
        exp_q = int'(prod >>> 15);
        run_window("test_zero_freq", -3000, 1500, exp_i, exp_q, 1'b0);

        $display("summary: %0d tests, %0d passed, %0d failed",
                 tests_run, tests_passed, tests_run - tests_passed);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
